// File: l2_front.f
source/l2_request_pkg.sv
source/l2_cache_pkg.sv
source/l2_req_if.sv
source/l2_cache_arb.sv
source/l2_miss_queue.sv
source/l2_tag_data.sv
source/l2_front.sv
verif/l2_front_props.sv
verif/l2_front_tb.sv

// File: Bender.yml
package:
  name: l2_front

sources:
  - source/l2_request_pkg.sv
  - source/l2_cache_pkg.sv
  - source/l2_req_if.sv
  - source/l2_cache_arb.sv
  - source/l2_miss_queue.sv
  - source/l2_tag_data.sv
  - source/l2_front.sv
  - target: test
    files:
      - verif/l2_front_props.sv
      - verif/l2_front_tb.sv

// File: verif/l2_front_tb.sv
`timescale 1ns/1ps

module l2_front_tb import l2_request_pkg::*;;

	localparam int NUM_ENTRIES = 16;

	typedef struct {
		l2_op_t op;
		line_addr_t addr;
		line_data_t data;
		byte_mask_t mask;
		int stall_cycles;
		bit drain;
	} entry_t;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic stall = 1'b0;
	logic req_valid = 1'b0;
	logic req_ready;
	unit_t req_unit = '0;
	strand_t req_strand = '0;
	l2_op_t req_op = op_load;
	line_addr_t req_addr = '0;
	line_data_t req_data = '0;
	byte_mask_t req_mask = '0;
	logic mem_rd;
	line_addr_t mem_rd_addr;
	logic mem_fill = 1'b0;
	line_data_t mem_fill_data = '0;
	logic resp_valid;
	unit_t resp_unit;
	strand_t resp_strand;
	l2_op_t resp_op;
	line_data_t resp_data;

	entry_t table_e [NUM_ENTRIES];
	// Scoreboard state, indexed by the request id {unit, strand}
	bit pend [NUM_ENTRIES];
	bit expect_hit [NUM_ENTRIES];
	int acc_cyc [NUM_ENTRIES];
	int outstanding = 0;
	int cyc = 0;
	line_data_t model [line_addr_t];
	bit cached [line_addr_t];
	int rd_count [line_addr_t];
	logic stall_edge = 1'b0;
	logic stall_prev = 1'b0;
	logic resp_valid_prev = 1'b0;
	line_data_t resp_data_prev = '0;
	bit saw_wait = 0;

	l2_front #(.MISS_QUEUE_DEPTH(4)) dut (.*);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		stall_edge <= stall;
	end

	// Memory contents seen by the cache, a function of the whole line address
	function automatic line_data_t fill_pattern(input line_addr_t a);
		line_data_t v;
		for (int i = 0; i < 8; i++)
			v[i*16 +: 16] = 16'(a * (i + 1)) ^ 16'h5a3c;
		return v;
	endfunction

	// Enabled bytes take the store data, the rest keep the old line
	function automatic line_data_t merge_line(input line_data_t old_l, input line_data_t d,
		input byte_mask_t m);
		line_data_t v;
		v = old_l;
		for (int i = 0; i < 16; i++)
			if (m[i])
				v[i*8 +: 8] = d[i*8 +: 8];
		return v;
	endfunction

	task automatic check_value(input string name, input line_data_t got, input line_data_t exp);
		assert (got === exp)
		else
		begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic stop_with(input string what);
		$display("Error at t=%0t: %s", $time, what);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic void set_entry(input int i, input l2_op_t op, input line_addr_t a,
		input byte_mask_t m, input int st, input bit dr);
		table_e[i].op = op;
		table_e[i].addr = a;
		table_e[i].data = {16{8'(8'h31 + i * 13)}};
		table_e[i].mask = m;
		table_e[i].stall_cycles = st;
		table_e[i].drain = dr;
	endfunction

	// Waits for ready, presents one request for one cycle, then applies its stall
	task automatic issue(input int i);
		line_addr_t a;
		a = table_e[i].addr;
		while (table_e[i].drain && outstanding != 0)
			@(posedge clk) #1;
		while (!req_ready)
			@(posedge clk) #1;
		req_valid = 1'b1;
		req_unit = unit_t'(i >> 2);
		req_strand = strand_t'(i);
		req_op = table_e[i].op;
		req_addr = a;
		req_data = table_e[i].data;
		req_mask = table_e[i].mask;
		pend[i] = 1;
		outstanding++;
		expect_hit[i] = cached.exists(a) && table_e[i].stall_cycles == 0;
		@(posedge clk) #1;
		acc_cyc[i] = cyc;
		req_valid = 1'b0;
		if (table_e[i].stall_cycles > 0)
		begin
			stall = 1'b1;
			repeat (table_e[i].stall_cycles) @(posedge clk) #1;
			stall = 1'b0;
		end
	endtask

	// Memory model, one read at a time with a random fill delay
	initial
	begin
		line_addr_t a;
		int d;
		void'($urandom(32'hcae89b34));
		forever
		begin
			@(negedge clk);
			if (!rst && mem_rd)
			begin
				a = mem_rd_addr;
				d = 3 + ($urandom % 8);
				repeat (d) @(posedge clk);
				#1 mem_fill = 1'b1;
				mem_fill_data = fill_pattern(a);
				@(posedge clk) #1 mem_fill = 1'b0;
			end
		end
	end

	// Outputs are sampled at the falling edge where they are stable
	always @(negedge clk)
	begin
		int id;
		line_addr_t a;
		line_data_t exp;
		if (!rst)
		begin
			if (dut.queue_wait)
				saw_wait = 1;
			if (mem_rd)
			begin
				assert (!rd_count.exists(mem_rd_addr))
				else stop_with("a line was read from memory twice");
				rd_count[mem_rd_addr] = 1;
			end
			if (stall)
			begin
				assert (!req_ready)
				else stop_with("req_ready high while stall is asserted");
			end
			if (stall && stall_prev)
			begin
				check_value("resp_valid", 128'(resp_valid), 128'(resp_valid_prev));
				check_value("resp_data", resp_data, resp_data_prev);
			end
			if (resp_valid && !stall_edge)
			begin
				id = {resp_unit, resp_strand};
				assert (pend[id])
				else stop_with("response for a request that is not outstanding");
				check_value("resp_op", 128'(resp_op), 128'(table_e[id].op));
				a = table_e[id].addr;
				if (!model.exists(a))
					model[a] = fill_pattern(a);
				if (table_e[id].op == op_store)
					model[a] = merge_line(model[a], table_e[id].data, table_e[id].mask);
				exp = model[a];
				check_value("resp_data", resp_data, exp);
				if (expect_hit[id])
					check_value("hit latency", 128'(cyc), 128'(acc_cyc[id] + 1));
				cached[a] = 1;
				pend[id] = 0;
				outstanding--;
			end
		end
		stall_prev = stall;
		resp_valid_prev = resp_valid;
		resp_data_prev = resp_data;
	end

	initial
	begin
		#(NUM_ENTRIES * 40 * 4);
		$display("Timeout: not every request got its response in time");
		$display("test failed");
		$fatal(1);
	end

	initial
	begin
		// Miss, back to back duplicate, then a hit on the filled line
		set_entry(0, op_load, 16'h0103, '0, 0, 0);
		set_entry(1, op_load, 16'h0103, '0, 0, 0);
		set_entry(2, op_load, 16'h0103, '0, 0, 1);
		// Masked store miss, then loads and stores that hit
		set_entry(3, op_store, 16'h0245, 16'h00f3, 0, 1);
		set_entry(4, op_load, 16'h0245, '0, 0, 1);
		set_entry(5, op_store, 16'h0103, 16'hf00f, 0, 0);
		set_entry(6, op_load, 16'h0103, '0, 0, 0);
		// Five distinct misses to fill the queue
		set_entry(7, op_load, 16'h040a, '0, 0, 1);
		set_entry(8, op_load, 16'h050b, '0, 0, 0);
		set_entry(9, op_load, 16'h060c, '0, 0, 0);
		set_entry(10, op_load, 16'h070d, '0, 0, 0);
		set_entry(11, op_load, 16'h080e, '0, 0, 0);
		// Stalls with requests in flight
		set_entry(12, op_store, 16'h0a21, 16'h0ff0, 6, 1);
		set_entry(13, op_load, 16'h0a21, '0, 3, 0);
		set_entry(14, op_load, 16'h040a, '0, 0, 1);
		set_entry(15, op_store, 16'h040a, 16'hffff, 2, 0);
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		for (int i = 0; i < NUM_ENTRIES; i++)
			issue(i);
		while (outstanding != 0)
			@(posedge clk) #1;
		for (int i = 0; i < NUM_ENTRIES; i++)
			assert (rd_count.exists(table_e[i].addr))
			else stop_with("a missed line was never read from memory");
		assert (saw_wait) else stop_with("queue back-pressure never closed req_ready");
		$display("test passed");
		$finish;
	end

endmodule

// File: verif/l2_front_props.sv
`timescale 1ns/1ps

module l2_front_props
(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic req_ready,
	input logic mem_rd,
	input logic mem_fill,
	input logic resp_valid
);

	// Set from a read strobe until its fill returns
	logic read_open;

	always_ff @(posedge clk)
	begin
		if (rst)
			read_open <= 1'b0;
		else if (mem_rd)
			read_open <= 1'b1;
		else if (mem_fill)
			read_open <= 1'b0;
	end

	// Stall must always close the core request port
	ready_low_in_stall: assert property (@(posedge clk) disable iff (rst) stall |-> !req_ready)
		else $error("req_ready high during stall");

	// Only one memory read may be outstanding
	single_read: assert property (@(posedge clk) disable iff (rst) mem_rd |-> !read_open)
		else $error("second mem_rd before mem_fill");

	resp_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(resp_valid))
		else $error("resp_valid unknown after reset");

endmodule

bind l2_front l2_front_props u_props (
	.clk(clk), .rst(rst), .stall(stall), .req_ready(req_ready),
	.mem_rd(mem_rd), .mem_fill(mem_fill), .resp_valid(resp_valid)
);

// File: source/l2_front.sv
`timescale 1ns/1ps

module l2_front import l2_request_pkg::*;
#(
	parameter int MISS_QUEUE_DEPTH = 4
)
(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic req_valid,
	output logic req_ready,
	input unit_t req_unit,
	input strand_t req_strand,
	input l2_op_t req_op,
	input line_addr_t req_addr,
	input line_data_t req_data,
	input byte_mask_t req_mask,
	output logic mem_rd,
	output line_addr_t mem_rd_addr,
	input logic mem_fill,
	input line_data_t mem_fill_data,
	output logic resp_valid,
	output unit_t resp_unit,
	output strand_t resp_strand,
	output l2_op_t resp_op,
	output line_data_t resp_data
);

	logic queue_wait;
	logic restart_taken;

	// Arbiter to lookup, queue back to arbiter, and lookup into the queue
	l2_req_if arb_to_pipe ();
	l2_req_if restart ();
	l2_req_if miss ();

	l2_cache_arb u_arb (
		.clk(clk), .rst(rst), .stall(stall),
		.req_valid(req_valid), .req_ready(req_ready),
		.req_unit(req_unit), .req_strand(req_strand), .req_op(req_op),
		.req_addr(req_addr), .req_data(req_data), .req_mask(req_mask),
		.restart(restart.restart_in), .queue_wait(queue_wait),
		.restart_taken(restart_taken), .to_pipe(arb_to_pipe.arb)
	);

	l2_tag_data u_tag_data (
		.clk(clk), .rst(rst), .stall(stall),
		.pipe_in(arb_to_pipe.pipe), .miss(miss.miss_out),
		.resp_valid(resp_valid), .resp_unit(resp_unit), .resp_strand(resp_strand),
		.resp_op(resp_op), .resp_data(resp_data)
	);

	l2_miss_queue #(.MISS_QUEUE_DEPTH(MISS_QUEUE_DEPTH)) u_miss_queue (
		.clk(clk), .rst(rst), .enq(miss.queue_in), .queue_wait(queue_wait),
		.restart(restart.queue_out), .restart_taken(restart_taken),
		.mem_rd(mem_rd), .mem_rd_addr(mem_rd_addr),
		.mem_fill(mem_fill), .mem_fill_data(mem_fill_data)
	);

endmodule

// File: source/l2_tag_data.sv
`timescale 1ns/1ps

module l2_tag_data import l2_request_pkg::*, l2_cache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic stall,
	l2_req_if.pipe pipe_in,
	l2_req_if.miss_out miss,
	output logic resp_valid,
	output unit_t resp_unit,
	output strand_t resp_strand,
	output l2_op_t resp_op,
	output line_data_t resp_data
);

	localparam int MASK_BITS = $bits(byte_mask_t);

	// Direct-mapped arrays, one entry per set
	line_tag_t tag_array [NUM_SETS];
	line_data_t data_array [NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits;

	set_index_t idx;
	line_tag_t tag;
	logic lookup;
	logic hit;
	logic present;
	line_data_t base_line;
	line_data_t new_line;

	assign idx = pipe_in.addr[INDEX_BITS-1:0];
	assign tag = pipe_in.addr[INDEX_BITS +: TAG_BITS];

	// The stage only acts when the arbiter holds a request and the pipe runs
	assign lookup = pipe_in.valid && !stall;
	assign hit = valid_bits[idx] && tag_array[idx] == tag;

	// A fill counts as present even before the arrays are written
	assign present = pipe_in.has_fill || hit;
	assign base_line = pipe_in.has_fill ? pipe_in.fill_data : data_array[idx];

	// Store data replaces only the enabled bytes
	always_comb
	begin
		new_line = base_line;
		if (pipe_in.op == op_store)
			for (int i = 0; i < MASK_BITS; i++)
				if (pipe_in.mask[i])
					new_line[i*8 +: 8] = pipe_in.data[i*8 +: 8];
	end

	// Valid bits and control flags
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_bits <= '0;
			resp_valid <= 1'b0;
			miss.valid <= 1'b0;
		end
		else
		begin
			if (lookup && pipe_in.has_fill)
				valid_bits[idx] <= 1'b1;
			// Response holds through a stall
			if (!stall)
				resp_valid <= lookup && present;
			// Enqueue is a single pulse even when a stall follows
			miss.valid <= lookup && !present;
		end
	end

	// Arrays, response payload and miss payload
	always_ff @(posedge clk)
	begin
		if (lookup && present)
		begin
			if (pipe_in.has_fill || pipe_in.op == op_store)
				data_array[idx] <= new_line;
			if (pipe_in.has_fill)
				tag_array[idx] <= tag;
			resp_unit <= pipe_in.unit;
			resp_strand <= pipe_in.strand;
			resp_op <= pipe_in.op;
			resp_data <= new_line;
		end
		if (lookup && !present)
		begin
			miss.unit <= pipe_in.unit;
			miss.strand <= pipe_in.strand;
			miss.op <= pipe_in.op;
			miss.addr <= pipe_in.addr;
			miss.data <= pipe_in.data;
			miss.mask <= pipe_in.mask;
		end
	end

	// The queue reads the line itself, nothing to pass on here
	assign miss.has_fill = 1'b0;
	assign miss.fill_data = '0;

endmodule

// File: source/l2_miss_queue.sv
`timescale 1ns/1ps

module l2_miss_queue import l2_request_pkg::*, l2_cache_pkg::*;
#(
	parameter int MISS_QUEUE_DEPTH = 4
)
(
	input logic clk,
	input logic rst,
	l2_req_if.queue_in enq,
	output logic queue_wait,
	l2_req_if.queue_out restart,
	input logic restart_taken,
	output logic mem_rd,
	output line_addr_t mem_rd_addr,
	input logic mem_fill,
	input line_data_t mem_fill_data
);

	localparam int PTR_BITS = $clog2(MISS_QUEUE_DEPTH);
	localparam int CNT_BITS = $clog2(MISS_QUEUE_DEPTH + 1);

	typedef logic [PTR_BITS-1:0] ptr_t;
	typedef logic [CNT_BITS-1:0] cnt_t;

	// Entry storage, written at the tail and read at the head
	unit_t ent_unit [MISS_QUEUE_DEPTH];
	strand_t ent_strand [MISS_QUEUE_DEPTH];
	l2_op_t ent_op [MISS_QUEUE_DEPTH];
	line_addr_t ent_addr [MISS_QUEUE_DEPTH];
	line_data_t ent_data [MISS_QUEUE_DEPTH];
	byte_mask_t ent_mask [MISS_QUEUE_DEPTH];
	logic ent_dup [MISS_QUEUE_DEPTH];
	logic [MISS_QUEUE_DEPTH-1:0] ent_valid;

	ptr_t head;
	ptr_t tail;
	cnt_t count;
	mq_state_t state;
	line_data_t fill_buf;
	logic enq_dup;

	// Pointers wrap by compare, so the depth need not be a power of two
	function automatic ptr_t next_ptr(input ptr_t p);
		return (p == ptr_t'(MISS_QUEUE_DEPTH - 1)) ? '0 : p + ptr_t'(1);
	endfunction

	// A miss on its way in already holds a slot
	// The arbiter register and a newly accepted request may need two more
	assign queue_wait = int'(count) + int'(enq.valid) >= MISS_QUEUE_DEPTH - 1;

	// A new miss to a line that some older entry already fetches is a duplicate
	always_comb
	begin
		enq_dup = 1'b0;
		for (int i = 0; i < MISS_QUEUE_DEPTH; i++)
			if (ent_valid[i] && ent_addr[i] == enq.addr)
				enq_dup = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (enq.valid)
		begin
			ent_unit[tail] <= enq.unit;
			ent_strand[tail] <= enq.strand;
			ent_op[tail] <= enq.op;
			ent_addr[tail] <= enq.addr;
			ent_data[tail] <= enq.data;
			ent_mask[tail] <= enq.mask;
			ent_dup[tail] <= enq_dup;
		end
		if (state == mq_wait_fill && mem_fill)
			fill_buf <= mem_fill_data;
	end

	// Pointers, count and the head sequencer
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			ent_valid <= '0;
			state <= mq_idle;
		end
		else
		begin
			if (enq.valid)
			begin
				tail <= next_ptr(tail);
				ent_valid[tail] <= 1'b1;
			end
			if (restart_taken)
			begin
				head <= next_ptr(head);
				ent_valid[head] <= 1'b0;
			end
			if (enq.valid && !restart_taken)
				count <= count + cnt_t'(1);
			else if (!enq.valid && restart_taken)
				count <= count - cnt_t'(1);

			case (state)
				// Duplicates skip memory entirely
				mq_idle:
					if (ent_valid[head])
						state <= ent_dup[head] ? mq_restart : mq_read;
				mq_read:
					state <= mq_wait_fill;
				mq_wait_fill:
					if (mem_fill)
						state <= mq_restart;
				mq_restart:
					if (restart_taken)
						state <= mq_idle;
				default:
					state <= mq_idle;
			endcase
		end
	end

	// Single read strobe, only one read is ever outstanding
	assign mem_rd = state == mq_read;
	assign mem_rd_addr = ent_addr[head];

	assign restart.valid = state == mq_restart;
	assign restart.unit = ent_unit[head];
	assign restart.strand = ent_strand[head];
	assign restart.op = ent_op[head];
	assign restart.addr = ent_addr[head];
	assign restart.data = ent_data[head];
	assign restart.mask = ent_mask[head];
	assign restart.has_fill = !ent_dup[head];
	assign restart.fill_data = fill_buf;

endmodule

// File: source/l2_cache_arb.sv
`timescale 1ns/1ps

module l2_cache_arb import l2_request_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic req_valid,
	output logic req_ready,
	input unit_t req_unit,
	input strand_t req_strand,
	input l2_op_t req_op,
	input line_addr_t req_addr,
	input line_data_t req_data,
	input byte_mask_t req_mask,
	l2_req_if.restart_in restart,
	input logic queue_wait,
	output logic restart_taken,
	l2_req_if.arb to_pipe
);

	// Core requests only get in when no restart is pending and the queue has room
	assign req_ready = !stall && !restart.valid && !queue_wait;

	// The queue pops its head on the same edge that this stage registers it
	assign restart_taken = !stall && restart.valid;

	// Valid holds through a stall so the item in flight is not dropped
	always_ff @(posedge clk)
	begin
		if (rst)
			to_pipe.valid <= 1'b0;
		else if (!stall)
			to_pipe.valid <= restart.valid || (req_valid && req_ready);
	end

	// Payload follows the winner; with no winner it is don't-care behind valid
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			if (restart.valid)
			begin
				to_pipe.unit <= restart.unit;
				to_pipe.strand <= restart.strand;
				to_pipe.op <= restart.op;
				to_pipe.addr <= restart.addr;
				to_pipe.data <= restart.data;
				to_pipe.mask <= restart.mask;
				to_pipe.has_fill <= restart.has_fill;
				to_pipe.fill_data <= restart.fill_data;
			end
			else
			begin
				to_pipe.unit <= req_unit;
				to_pipe.strand <= req_strand;
				to_pipe.op <= req_op;
				to_pipe.addr <= req_addr;
				to_pipe.data <= req_data;
				to_pipe.mask <= req_mask;
				// Core requests never bring a line with them
				to_pipe.has_fill <= 1'b0;
				to_pipe.fill_data <= '0;
			end
		end
	end

endmodule

// File: source/l2_req_if.sv
`timescale 1ns/1ps

interface l2_req_if import l2_request_pkg::*; ();

	logic valid;
	unit_t unit;
	strand_t strand;
	l2_op_t op;
	line_addr_t addr;
	line_data_t data;
	byte_mask_t mask;

	// Set when fill_data carries the line read from memory
	logic has_fill;
	line_data_t fill_data;

	// Arbiter register into the tag and data stage
	modport arb (output valid, unit, strand, op, addr, data, mask, has_fill, fill_data);
	modport pipe (input valid, unit, strand, op, addr, data, mask, has_fill, fill_data);

	// Restarted requests from the miss queue back to the arbiter
	modport queue_out (output valid, unit, strand, op, addr, data, mask, has_fill, fill_data);
	modport restart_in (input valid, unit, strand, op, addr, data, mask, has_fill, fill_data);

	// Miss enqueue; the fill fields are tied off by the sender
	modport miss_out (output valid, unit, strand, op, addr, data, mask, has_fill, fill_data);
	modport queue_in (input valid, unit, strand, op, addr, data, mask);

endinterface

// File: source/l2_cache_pkg.sv
package l2_cache_pkg;

	import l2_request_pkg::*;

	// Direct-mapped geometry, 64 lines
	localparam int INDEX_BITS = 6;

	// Whatever is left of the line address above the index becomes the tag
	localparam int TAG_BITS = $bits(line_addr_t) - INDEX_BITS;
	localparam int NUM_SETS = 1 << INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] set_index_t;
	typedef logic [TAG_BITS-1:0] line_tag_t;

	// Head entry sequencer of the miss queue
	typedef enum logic [1:0]
	{
		mq_idle,
		mq_read,
		mq_wait_fill,
		mq_restart
	} mq_state_t;

endpackage

// File: source/l2_request_pkg.sv
package l2_request_pkg;

	// Core unit that issued the request, echoed back on the response
	typedef logic [1:0] unit_t;

	// Hardware strand inside the unit
	typedef logic [1:0] strand_t;

	// Request opcode; only loads and stores are used, the other codes are spare
	typedef enum logic [2:0]
	{
		op_load  = 3'd0,
		op_store = 3'd1
	} l2_op_t;

	// Line address, byte offset within the line already removed
	typedef logic [15:0] line_addr_t;

	// One full cache line of 16 bytes
	typedef logic [127:0] line_data_t;

	// Store byte enables, one bit per byte of the line
	typedef logic [15:0] byte_mask_t;

endpackage
